// File: mips_cases.txt
// case count, then per case: program count and words; data count and address/word pairs;
// write count and address/lanes pairs in order; final count and address/word pairs.
00000006
// alu, shift and immediates stored by sw.
00000011
20010005 2002FFFD 00221820 00222022 00222824 00223025 0041382A 00014100 34098001
AC030100 AC040104 AC050108 AC06010C AC070110 AC080114 AC090118 0000000C
00000000
00000007
00000100 00000002 00000104 00000008 00000108 00000005 0000010C FFFFFFFD
00000110 00000001 00000114 00000050 00000118 00008001
00000002
00000100 00000002 00000118 00008001
// lw miss then hit, copied with sw.
00000005
8C010200 AC010204 8C020200 AC020208 0000000C
00000001
00000200 12345678
00000002
00000204 12345678 00000208 12345678
00000003
00000200 12345678 00000204 12345678 00000208 12345678
// lb of all four lanes.
00000009
80010300 80020301 80030302 80040303 AC010310 AC020314 AC030318 AC04031C 0000000C
00000001
00000300 80FF7F01
00000004
00000310 FFFFFF80 00000314 FFFFFFFF 00000318 0000007F 0000031C 00000001
00000005
00000300 80FF7F01 00000310 FFFFFF80 00000314 FFFFFFFF 00000318 0000007F 0000031C 00000001
// sb miss, sb miss, sb hit.
00000005
340100EE A0010401 A0010407 A0010400 0000000C
00000002
00000400 11223344 00000404 AABBCCDD
00000003
00000400 11EE3344 00000404 AABBCCEE 00000400 EEEE3344
00000002
00000400 EEEE3344 00000404 AABBCCEE
// beq, bne, jal, jr and j around skipped stores.
00000010
20010001 20020001 10220001 AC010500 14200001 AC010504 10200001 AC020508
0C00000B AC01050C 0800000E AC1F0510 03E00008 AC010514 AC020518 0000000C
00000004
00000500 CAFE0000 00000504 CAFE0004 0000050C CAFE000C 00000514 CAFE0014
00000003
00000508 00000001 00000510 00000028 00000518 00000001
00000004
00000500 CAFE0000 00000504 CAFE0004 0000050C CAFE000C 00000514 CAFE0014
// syscall stops the store behind it.
00000004
20010007 AC010600 0000000C AC010604
00000001
00000604 0BADF00D
00000001
00000600 00000007
00000002
00000600 00000007 00000604 0BADF00D

// File: src.f
mips_isa_pkg.sv
mips_mem_pkg.sv
mips_control.sv
mips_alu.sv
mips_regfile.sv
mips_dcache.sv
mips_core.sv
mips_core_assertions.sv
mips_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: mips_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core_tb import mips_mem_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int CASE_CYCLES  = 200;
    localparam int HALT_WINDOW  = 4;     // cycles watched after halt for stray writes.
    localparam int IMEM_WORDS   = 64;
    localparam int DMEM_WORDS   = 1024;
    localparam int CASE_WORDS   = 1024;

    logic        clk;
    logic        rst_b;
    logic [31:0] inst_addr;
    logic [31:0] inst;
    logic [31:0] mem_addr;
    byte_lanes_t mem_data_out;
    byte_lanes_t mem_data_in;
    logic        mem_write_en;
    logic        halted;

    logic [31:0] imem [IMEM_WORDS];
    byte_lanes_t dmem [DMEM_WORDS];
    logic [31:0] case_words [CASE_WORDS];

    int num_cases;
    int ptr;
    int seed;
    int write_count;
    int expected_writes;

    logic [31:0] exp_addr_q [$];
    byte_lanes_t exp_lanes_q [$];
    logic [31:0] final_addr_q [$];
    byte_lanes_t final_word_q [$];

    // both memories answer combinationally.
    assign inst         = imem[inst_addr[7:2]];
    assign mem_data_out = dmem[mem_addr[11:2]];

    mips_core mips_core_i (
        .inst_addr    (inst_addr),
        .inst         (inst),
        .mem_addr     (mem_addr),
        .mem_data_out (mem_data_out),
        .mem_data_in  (mem_data_in),
        .mem_write_en (mem_write_en),
        .halted       (halted),
        .clk          (clk),
        .rst_b        (rst_b)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_store(input logic [31:0] addr, input byte_lanes_t lanes);
        logic [31:0] exp_addr;
        byte_lanes_t exp_lanes;
        if (exp_addr_q.size() == 0) begin
            stop_run($sformatf("An unexpected memory write went to address %h.", addr));
        end
        exp_addr  = exp_addr_q.pop_front();
        exp_lanes = exp_lanes_q.pop_front();
        if (addr !== exp_addr || lanes !== exp_lanes) begin
            stop_run($sformatf("ERROR at %0t: store %h <= %h, expected %h <= %h",
                               $time, addr, lanes, exp_addr, exp_lanes));
        end
    endtask

    task automatic check_word(input logic [31:0] addr, input byte_lanes_t expected);
        if (dmem[addr[11:2]] !== expected) begin
            stop_run($sformatf("ERROR at %0t: word %h is %h, expected %h",
                               $time, addr, dmem[addr[11:2]], expected));
        end
    endtask

    task automatic check_halt(input logic seen, input int writes, input int expected);
        if (!seen) begin
            stop_run("The core did not stay halted after the system call.");
        end
        if (writes != expected) begin
            stop_run($sformatf("The core made %0d memory writes instead of %0d.",
                               writes, expected));
        end
    endtask

    // memory writes land at the rising edge.
    always @(posedge clk) begin
        if (rst_b && mem_write_en) begin
            check_store(mem_addr, mem_data_in);
            write_count++;
            dmem[mem_addr[11:2]] <= mem_data_in;
        end
    end

    task automatic load_case();
        int          n;
        logic [31:0] a;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'h0000000c;              // stray fetches halt.
        end
        n = case_words[ptr];
        ptr++;
        for (int i = 0; i < n; i++) begin
            imem[i] = case_words[ptr];
            ptr++;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= byte_lanes_t'($random(seed) ^ (i * 4));
        end
        n = case_words[ptr];
        ptr++;
        for (int i = 0; i < n; i++) begin
            a = case_words[ptr];
            dmem[a[11:2]] <= case_words[ptr + 1];
            ptr += 2;
        end
        n = case_words[ptr];                     // expected writes, in order.
        ptr++;
        expected_writes = n;
        for (int i = 0; i < n; i++) begin
            exp_addr_q.push_back(case_words[ptr]);
            exp_lanes_q.push_back(case_words[ptr + 1]);
            ptr += 2;
        end
        n = case_words[ptr];
        ptr++;
        for (int i = 0; i < n; i++) begin
            final_addr_q.push_back(case_words[ptr]);
            final_word_q.push_back(case_words[ptr + 1]);
            ptr += 2;
        end
    endtask

    initial begin
        rst_b       = 1'b0;
        seed        = 32'haa7cac55;
        num_cases   = 0;
        write_count = 0;
        $readmemh("mips_cases.txt", case_words);
        num_cases = case_words[0];
        ptr       = 1;
        if (num_cases == 0) begin
            stop_run("No cases were found in mips_cases.txt.");
        end
        for (int c = 0; c < num_cases; c++) begin
            @(posedge clk);
            #1 rst_b = 1'b0;
            exp_addr_q.delete();
            exp_lanes_q.delete();
            final_addr_q.delete();
            final_word_q.delete();
            write_count = 0;
            load_case();
            repeat (RESET_CYCLES) @(posedge clk);
            #1 rst_b = 1'b1;
            do begin
                @(posedge clk);
            end while (!halted);
            repeat (HALT_WINDOW) @(posedge clk);
            check_halt(halted, write_count, expected_writes);
            while (final_addr_q.size() > 0) begin
                check_word(final_addr_q.pop_front(), final_word_q.pop_front());
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // each case gets its reset, its run budget and the halt window.
    initial begin
        wait (num_cases > 0);
        #(CLK_PERIOD * (CASE_CYCLES + RESET_CYCLES + HALT_WINDOW + 2) * num_cases);
        stop_run("The watchdog timed out before all cases finished.");
    end

endmodule

`default_nettype wire

// File: mips_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core_assertions import mips_mem_pkg::*; (
    input logic        clk,
    input logic        rst_b,
    input logic        halted,
    input logic        mem_write_en,
    input logic        stall,
    input logic [31:0] pc,
    input dc_req_t     dc_req
);

    // no write once the core has halted.
    assert property (@(posedge clk) disable iff (!rst_b) halted |-> !mem_write_en)
        else $error("memory write while halted");

    // pc held over a pending miss.
    assert property (@(posedge clk) disable iff (!rst_b) stall |=> pc == $past(pc))
        else $error("pc moved while the data access was pending");

    // writes only come from a store.
    assert property (@(posedge clk) disable iff (!rst_b)
        mem_write_en |-> (dc_req.op == DC_STORE_W || dc_req.op == DC_STORE_B))
        else $error("memory write without a store");

endmodule

bind mips_core mips_core_assertions assertions_i (
    .clk          (clk),
    .rst_b        (rst_b),
    .halted       (halted),
    .mem_write_en (mem_write_en),
    .stall        (stall),
    .pc           (pc),
    .dc_req       (dc_req)
);

`default_nettype wire

// File: mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core import mips_isa_pkg::*, mips_mem_pkg::*; (
    output logic [31:0] inst_addr,
    input  logic [31:0] inst,
    output logic [31:0] mem_addr,
    input  byte_lanes_t mem_data_out,
    output byte_lanes_t mem_data_in,
    output logic        mem_write_en,
    output logic        halted,
    input  logic        clk,
    input  logic        rst_b
);

    ctrl_t ctrl;

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;

    logic [4:0]      rs_num;
    logic [4:0]      rt_num;
    logic [4:0]      rd_num;
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;
    logic [XLEN-1:0] rd_data;
    logic            rd_we;

    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;

    dc_req_t     dc_req;
    dc_rsp_t     dc_rsp;
    logic [1:0]  byte_sel;
    logic [7:0]  load_byte;
    logic [31:0] load_data;
    byte_lanes_t store_lanes;

    logic stall;
    logic advance;
    logic br_taken;

    mips_control control_i (
        .inst (inst),
        .ctrl (ctrl)
    );

    assign rs_num = inst[RS_LSB +: 5];
    assign rt_num = inst[RT_LSB +: 5];
    assign rd_num = ctrl.link ? 5'd31 : (ctrl.reg_dst ? inst[RD_LSB +: 5] : rt_num);

    mips_regfile regfile_i (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rd_num  (rd_num),
        .rd_data (rd_data),
        .rd_we   (rd_we),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    assign imm_ext = ctrl.sign_ext ? {{16{inst[15]}}, inst[15:0]} : {16'd0, inst[15:0]};
    assign alu_a   = ctrl.shamt_src ? {27'd0, inst[SHAMT_LSB +: 5]} : rs_data;
    assign alu_b   = ctrl.alu_src ? imm_ext : rt_data;

    mips_alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // data side. lane 0 is byte address 0.
    assign byte_sel  = alu_result[1:0];
    assign load_byte = dc_rsp.rdata[byte_sel];
    assign load_data = ctrl.mem_byte ? {{24{load_byte[7]}}, load_byte} : dc_rsp.rdata;

    always_comb begin
        if (ctrl.mem_byte) begin
            store_lanes           = dc_rsp.rdata;    // read-modify-write of the word.
            store_lanes[byte_sel] = rt_data[7:0];
        end else begin
            store_lanes = rt_data;
        end
    end

    always_comb begin
        if (ctrl.mem_to_reg) begin
            dc_req.op = DC_LOAD;
        end else if (ctrl.mem_store) begin
            dc_req.op = ctrl.mem_byte ? DC_STORE_B : DC_STORE_W;
        end else begin
            dc_req.op = DC_NONE;
        end
    end

    assign dc_req.addr  = alu_result[31:2];
    assign dc_req.wdata = store_lanes;

    mips_dcache dcache_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .req          (dc_req),
        .rsp          (dc_rsp),
        .mem_addr     (mem_addr),
        .mem_data_out (mem_data_out),
        .mem_data_in  (mem_data_in),
        .mem_write_en (mem_write_en)
    );

    assign halted  = (inst[OP_LSB +: 6] == OP_RTYPE) && (inst[5:0] == HALT_FUNCT);
    assign stall   = (dc_req.op != DC_NONE) && !dc_rsp.done;
    assign advance = !stall && !halted;

    // jal links pc+8.
    assign rd_data = ctrl.link ? pc + 32'd8 : (ctrl.mem_to_reg ? load_data : alu_result);
    assign rd_we   = ctrl.reg_write && advance;

    assign pc_plus4 = pc + 32'd4;
    assign br_taken = alu_zero ^ ctrl.br_ne;

    always_comb begin
        case (ctrl.pc_sel)
            PC_BRANCH: next_pc = br_taken ? pc_plus4 + {imm_ext[29:0], 2'b00} : pc_plus4;
            PC_JUMP:   next_pc = {pc_plus4[31:28], inst[25:0], 2'b00};
            PC_REG:    next_pc = rs_data;
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk, negedge rst_b) begin
        if (!rst_b) begin
            pc <= '0;
        end else if (advance) begin
            pc <= next_pc;             // held on a miss and after halt.
        end
    end

    assign inst_addr = pc;

endmodule

`default_nettype wire

// File: mips_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module mips_dcache import mips_mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_b,
    input  dc_req_t     req,
    output dc_rsp_t     rsp,
    output logic [31:0] mem_addr,
    input  byte_lanes_t mem_data_out,
    output byte_lanes_t mem_data_in,
    output logic        mem_write_en
);

    typedef enum logic {
        ST_IDLE,
        ST_FILL
    } dc_state_e;

    dc_state_e state;
    logic [FILL_CNT_BITS-1:0] fill_cnt;

    logic [DC_LINES-1:0]    valid;
    logic [DC_TAG_BITS-1:0] tags [DC_LINES];
    byte_lanes_t            lines [DC_LINES];

    logic [DC_INDEX_BITS-1:0] index;
    logic [DC_TAG_BITS-1:0]   tag;
    logic hit;
    logic lookup;        // load or byte store, needs the line.
    logic fill_last;
    logic line_write;

    assign index  = req.addr[DC_INDEX_BITS-1:0];
    assign tag    = req.addr[DC_INDEX_BITS +: DC_TAG_BITS];
    assign hit    = valid[index] && (tags[index] == tag);
    assign lookup = (req.op == DC_LOAD) || (req.op == DC_STORE_B);

    assign fill_last = (state == ST_FILL) && (fill_cnt == FILL_CNT_BITS'(FILL_CYCLES - 1));

    // memory sees the request address throughout, fills included.
    assign mem_addr    = {req.addr, 2'b00};
    assign mem_data_in = req.wdata;

    // word stores go out at once. byte stores wait for the merged word.
    assign mem_write_en = (state == ST_IDLE) &&
                          ((req.op == DC_STORE_W) || (req.op == DC_STORE_B && hit));

    assign rsp.rdata = lines[index];
    assign rsp.done  = (state == ST_IDLE) && ((req.op == DC_STORE_W) || (lookup && hit));

    // a store that hits keeps the line in step with memory.
    assign line_write = mem_write_en && hit;

    always_ff @(posedge clk, negedge rst_b) begin
        if (!rst_b) begin
            state    <= ST_IDLE;
            fill_cnt <= '0;
            valid    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (lookup && !hit) begin
                        state    <= ST_FILL;
                        fill_cnt <= '0;
                    end
                end
                ST_FILL: begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_last) begin
                        state        <= ST_IDLE;
                        valid[index] <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill_last) begin
            lines[index] <= mem_data_out;
            tags[index]  <= tag;
        end else if (line_write) begin
            lines[index] <= req.wdata;
        end
    end

endmodule

`default_nettype wire

// File: mips_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module mips_regfile import mips_isa_pkg::*; (
    input  logic            clk,
    input  logic            rst_b,
    input  logic [4:0]      rs_num,
    input  logic [4:0]      rt_num,
    input  logic [4:0]      rd_num,
    input  logic [XLEN-1:0] rd_data,
    input  logic            rd_we,
    output logic [XLEN-1:0] rs_data,
    output logic [XLEN-1:0] rt_data
);

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk, negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_num != 5'd0) begin
            regs[rd_num] <= rd_data;
        end
    end

    // r0 reads as zero.
    assign rs_data = (rs_num == 5'd0) ? '0 : regs[rs_num];
    assign rt_data = (rt_num == 5'd0) ? '0 : regs[rt_num];

endmodule

`default_nettype wire

// File: mips_alu.sv
`timescale 1ns/100ps
`default_nettype none

module mips_alu import mips_isa_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // signed compare.
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLL: result = b << a[4:0];    // shift amount comes in on a.
            default: result = b;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: mips_control.sv
`timescale 1ns/100ps
`default_nettype none

module mips_control import mips_isa_pkg::*; (
    input  logic [31:0] inst,
    output ctrl_t       ctrl
);

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(inst[OP_LSB +: 6]);
    assign funct  = funct_e'(inst[5:0]);

    always_comb begin
        ctrl        = '0;              // no-op unless decoded below.
        ctrl.pc_sel = PC_SEQ;
        ctrl.alu_op = ALU_PASS_B;

        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    F_ADD: ctrl.alu_op = ALU_ADD;
                    F_SUB: ctrl.alu_op = ALU_SUB;
                    F_AND: ctrl.alu_op = ALU_AND;
                    F_OR:  ctrl.alu_op = ALU_OR;
                    F_SLT: ctrl.alu_op = ALU_SLT;
                    F_SLL: begin
                        ctrl.alu_op    = ALU_SLL;
                        ctrl.shamt_src = 1'b1;
                    end
                    F_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.pc_sel    = PC_REG;
                    end
                    default: ctrl.reg_write = 1'b0;  // syscall and unknown.
                endcase
            end
            OP_ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.sign_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_ORI: begin
                ctrl.alu_src   = 1'b1;            // zero extended.
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OR;
            end
            OP_LW, OP_LB: begin
                ctrl.alu_src    = 1'b1;
                ctrl.sign_ext   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_byte   = (opcode == OP_LB);
                ctrl.alu_op     = ALU_ADD;
            end
            OP_SW, OP_SB: begin
                ctrl.alu_src   = 1'b1;
                ctrl.sign_ext  = 1'b1;
                ctrl.mem_store = 1'b1;
                ctrl.mem_byte  = (opcode == OP_SB);
                ctrl.alu_op    = ALU_ADD;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.sign_ext = 1'b1;             // offset sign extends.
                ctrl.br_ne    = (opcode == OP_BNE);
                ctrl.pc_sel   = PC_BRANCH;
                ctrl.alu_op   = ALU_SUB;
            end
            OP_J: ctrl.pc_sel = PC_JUMP;
            OP_JAL: begin
                ctrl.pc_sel    = PC_JUMP;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

    // one word per line.
    localparam int DC_LINES       = 16;
    localparam int DC_INDEX_BITS  = 4;
    localparam int DC_TAG_BITS    = 26;
    localparam int WORD_ADDR_BITS = DC_TAG_BITS + DC_INDEX_BITS;

    localparam int FILL_CYCLES   = 3;
    localparam int FILL_CNT_BITS = $clog2(FILL_CYCLES + 1);

    // lane 0 is the most significant byte.
    typedef logic [0:3][7:0] byte_lanes_t;

    typedef enum logic [1:0] {
        DC_NONE,
        DC_LOAD,
        DC_STORE_W,
        DC_STORE_B
    } dc_op_e;

    typedef struct packed {
        dc_op_e                    op;
        logic [WORD_ADDR_BITS-1:0] addr;   // word address.
        byte_lanes_t               wdata;
    } dc_req_t;

    typedef struct packed {
        byte_lanes_t rdata;
        logic        done;
    } dc_rsp_t;

endpackage

`default_nettype wire

// File: mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    // bit positions of the instruction fields.
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LB    = 6'h20,
        OP_LW    = 6'h23,
        OP_SB    = 6'h28,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL     = 6'h00,
        F_JR      = 6'h08,
        F_SYSCALL = 6'h0c,
        F_ADD     = 6'h20,
        F_SUB     = 6'h22,
        F_AND     = 6'h24,
        F_OR      = 6'h25,
        F_SLT     = 6'h2a
    } funct_e;

    localparam funct_e HALT_FUNCT = F_SYSCALL;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JUMP,
        PC_REG
    } pc_sel_e;

    typedef struct packed {
        logic    reg_dst;     // write rd instead of rt.
        logic    link;        // write return address to r31.
        logic    alu_src;     // immediate as operand b.
        logic    shamt_src;   // shift amount as operand a.
        logic    sign_ext;
        logic    reg_write;
        logic    mem_to_reg;  // load, write back memory data.
        logic    mem_store;
        logic    mem_byte;    // lb or sb.
        logic    br_ne;       // branch on not equal, else on equal.
        pc_sel_e pc_sel;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

`default_nettype wire
